// ==== verilog/aes_pkg.sv ====
// ==========================================================================
// AES core shared definitions
// Mode, FSM state and mux select codes, round limits and GF(2^8) doubling
// ==========================================================================
package aes_pkg;

	// Chaining modes
	// Codes 01 and 11 run as ECB
	localparam logic [1:0] ECB = 2'b00;
	localparam logic [1:0] CTR = 2'b10;

	// Sequencer states
	typedef enum logic [3:0] {
		IDLE        = 4'd0,
		ROUND0_COL0 = 4'd1,
		ROUND0_COL1 = 4'd2,
		ROUND0_COL2 = 4'd3,
		ROUND0_COL3 = 4'd4,
		ROUND_KEY   = 4'd5,
		ROUND_COL0  = 4'd6,
		ROUND_COL1  = 4'd7,
		ROUND_COL2  = 4'd8,
		ROUND_COL3  = 4'd9,
		READY       = 4'd10
	} aes_state_t;

	// Shared S-box input select
	localparam logic [2:0] SEL_COL0   = 3'b000;
	localparam logic [2:0] SEL_COL1   = 3'b001;
	localparam logic [2:0] SEL_COL2   = 3'b010;
	localparam logic [2:0] SEL_COL3   = 3'b011;
	localparam logic [2:0] G_FUNCTION = 3'b100;

	// Column capture select
	localparam logic [1:0] SHIFT_ROWS = 2'b00;
	localparam logic [1:0] ADD_RK_OUT = 2'b01;
	localparam logic [1:0] LOAD_INPUT = 2'b10;

	// Round limits
	localparam logic [3:0] NUMBER_ROUND  = 4'd10;
	localparam logic [3:0] INITIAL_ROUND = 4'd0;

	// Multiply by x in GF(2^8), AES polynomial
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

// ==== verilog/aes_sbox.sv ====
// ==========================================================================
// AES forward S-box
// Four byte lookups in parallel on one 32-bit word
// ==========================================================================
`timescale 1ns/1ps

module aes_sbox
(
	input  logic [31:0] word_in,
	output logic [31:0] word_out
);

// ==========================================================================
// Substitution table
// ==========================================================================
// Entry 0 sits in the most significant byte
localparam logic [0:255][7:0] SBOX = {
	256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
	256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
	256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
	256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
	256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
	256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
	256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
	256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
};

// ==========================================================================
// Byte lanes
// ==========================================================================
// Lane 0 is the top byte, row 0 of a column
genvar lane;
generate
	for (lane = 0; lane < 4; lane++)
	begin : g_lane
		assign word_out[31 - 8*lane -: 8] = SBOX[word_in[31 - 8*lane -: 8]];
	end
endgenerate

endmodule

// ==== verilog/aes_control_unit.sv ====
// ==========================================================================
// AES round sequencer
// Steps the column-serial rounds and drives all datapath enables and selects
// ==========================================================================
`timescale 1ns/1ps

module aes_control_unit
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       disable_core,
	input  logic [1:0] aes_mode,
	output logic       key_init,
	output logic [2:0] sbox_sel,
	output logic [1:0] col_sel,
	output logic [3:0] col_en,
	output logic [3:0] key_en,
	output logic [3:0] round,
	output logic       last_round,
	output logic       end_comp
);

aes_state_t state;
aes_state_t next_state;
logic [3:0] rd_count;
logic       rd_count_en;
logic       mode_ctr;
logic       mode_ctr_q;
logic       mode_change;

// Busy starts are dropped here
assign key_init = start && (state == IDLE);

// Counter block muxes follow aes_mode live
// A mode change mid-block would mix ECB and CTR results
assign mode_ctr    = (aes_mode == CTR);
assign mode_change = (state != IDLE) && (mode_ctr != mode_ctr_q);

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		mode_ctr_q <= 1'b0;
	else if (key_init)
		mode_ctr_q <= mode_ctr;
end

// ==========================================================================
// State register and next state
// ==========================================================================
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		state <= IDLE;
	else if (disable_core || mode_change)
		state <= IDLE;
	else
		state <= next_state;
end

always_comb
begin
	next_state = state;
	case (state)
		IDLE:        next_state = key_init ? ROUND0_COL0 : IDLE;
		ROUND0_COL0: next_state = ROUND0_COL1;
		ROUND0_COL1: next_state = ROUND0_COL2;
		ROUND0_COL2: next_state = ROUND0_COL3;
		ROUND0_COL3: next_state = ROUND_KEY;
		ROUND_KEY:   next_state = ROUND_COL0;
		ROUND_COL0:  next_state = ROUND_COL1;
		ROUND_COL1:  next_state = ROUND_COL2;
		ROUND_COL2:  next_state = ROUND_COL3;
		ROUND_COL3:  next_state = last_round ? READY : ROUND_KEY;
		default:     next_state = IDLE;
	endcase
end

// ==========================================================================
// Datapath controls
// ==========================================================================
always_comb
begin
	sbox_sel    = SEL_COL0;
	col_sel     = LOAD_INPUT;
	col_en      = 4'b0000;
	key_en      = 4'b0000;
	rd_count_en = 1'b0;
	case (state)
		ROUND0_COL0, ROUND_COL0:
		begin
			sbox_sel = SEL_COL0;
			col_sel  = ADD_RK_OUT;
			col_en   = 4'b0001;
		end
		ROUND0_COL1, ROUND_COL1:
		begin
			sbox_sel = SEL_COL1;
			col_sel  = ADD_RK_OUT;
			col_en   = 4'b0010;
			key_en   = (state == ROUND_COL1) ? 4'b0010 : 4'b0000;
		end
		ROUND0_COL2, ROUND_COL2:
		begin
			sbox_sel = SEL_COL2;
			col_sel  = ADD_RK_OUT;
			col_en   = 4'b0100;
			key_en   = (state == ROUND_COL2) ? 4'b0100 : 4'b0000;
		end
		ROUND0_COL3, ROUND_COL3:
		begin
			// Last column closes the round with ShiftRows, except in round 10
			sbox_sel = SEL_COL3;
			col_sel  = last_round ? ADD_RK_OUT : SHIFT_ROWS;
			col_en   = 4'b1000;
			key_en   = (state == ROUND_COL3) ? 4'b1000 : 4'b0000;
		end
		ROUND_KEY:
		begin
			// S-box lent to the G function for key word 0
			sbox_sel    = G_FUNCTION;
			key_en      = 4'b0001;
			rd_count_en = 1'b1;
		end
		default:
		begin
			col_sel = LOAD_INPUT;
		end
	endcase
end

// Round counter, counts ROUND_KEY visits
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		rd_count <= INITIAL_ROUND;
	else if (state == IDLE)
		rd_count <= INITIAL_ROUND;
	else if (rd_count_en)
		rd_count <= rd_count + 1'b1;
end

assign round      = rd_count;
assign last_round = (rd_count == NUMBER_ROUND);
assign end_comp   = (state == READY);

endmodule

// ==== verilog/aes_key_schedule.sv ====
// ==========================================================================
// AES-128 on-the-fly key schedule
// One round-key word per cycle with forwarding of the fresh word
// ==========================================================================
`timescale 1ns/1ps

module aes_key_schedule
	import aes_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         key_init,
	input  logic [127:0] key_in,
	input  logic [3:0]   key_en,
	input  logic [3:0]   round,
	input  logic [31:0]  sbox_out,
	output logic [127:0] rk
);

logic [31:0] w [4];
logic [31:0] w_next [4];
logic [7:0]  rcon;

// rcon doubles once per completed round
always_comb
begin
	rcon = 8'h01;
	for (int i = INITIAL_ROUND; i < NUMBER_ROUND; i++)
	begin
		if (i < round)
			rcon = xtime(rcon);
	end
end

// Word 0 takes SubWord(RotWord(w3)) from the shared S-box
// Words 1 to 3 chain off the word below
always_comb
begin
	w_next[0] = w[0] ^ sbox_out ^ {rcon, 24'h000000};
	for (int c = 1; c < 4; c++)
		w_next[c] = w[c] ^ w[c-1];
end

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		for (int c = 0; c < 4; c++)
			w[c] <= 32'h0;
	end
	else if (key_init)
	begin
		for (int c = 0; c < 4; c++)
			w[c] <= key_in[(3-c)*32 +: 32];
	end
	else
	begin
		for (int c = 0; c < 4; c++)
			if (key_en[c])
				w[c] <= w_next[c];
	end
end

// Forward the word being written so the column sees it this cycle
always_comb
begin
	for (int c = 0; c < 4; c++)
		rk[(3-c)*32 +: 32] = key_en[c] ? w_next[c] : w[c];
end

endmodule

// ==== verilog/aes_state_columns.sv ====
// ==========================================================================
// AES state columns
// Column-serial SubBytes, MixColumns, AddRoundKey and whole-state ShiftRows
// ==========================================================================
`timescale 1ns/1ps

module aes_state_columns
	import aes_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         key_init,
	input  logic [127:0] block_in,
	input  logic [2:0]   sbox_sel,
	input  logic [1:0]   col_sel,
	input  logic [3:0]   col_en,
	input  logic         last_round,
	input  logic [127:0] rk,
	output logic [31:0]  sbox_out,
	output logic [127:0] state_out
);

logic [31:0] col [4];
logic [31:0] upd [4];
logic [31:0] shifted [4];
logic [31:0] col_next [4];
logic [1:0]  idx;
logic [31:0] sbox_in;
logic [31:0] rk_word;
logic [31:0] ark_col;
logic [3:0]  col_we;
logic        first_round;

// MixColumns on one column, row 0 in the top byte
function automatic logic [31:0] mix_column(input logic [31:0] a);
	logic [7:0] a0;
	logic [7:0] a1;
	logic [7:0] a2;
	logic [7:0] a3;
	a0 = a[31:24];
	a1 = a[23:16];
	a2 = a[15:8];
	a3 = a[7:0];
	return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
		a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
		a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
		xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
endfunction

// ==========================================================================
// Shared S-box and column arithmetic
// ==========================================================================
assign idx     = sbox_sel[1:0];
// G function feeds RotWord of key word 3
assign sbox_in = (sbox_sel == G_FUNCTION) ? {rk[23:0], rk[31:24]} : col[idx];

aes_sbox u_sbox
(
	.word_in  (sbox_in),
	.word_out (sbox_out)
);

assign rk_word = rk[(3 - idx)*32 +: 32];

// Round 0 adds the key to the raw input
always_comb
begin
	if (first_round)
		ark_col = col[idx] ^ rk_word;
	else if (last_round)
		ark_col = sbox_out ^ rk_word;
	else
		ark_col = mix_column(sbox_out) ^ rk_word;
end

// Row r rotates left by r columns
// The column finishing this cycle enters the shift with its new value
always_comb
begin
	for (int c = 0; c < 4; c++)
		upd[c] = col_en[c] ? ark_col : col[c];
	for (int c = 0; c < 4; c++)
		for (int r = 0; r < 4; r++)
			shifted[c][31 - 8*r -: 8] = upd[(c + r) % 4][31 - 8*r -: 8];
end

always_comb
begin
	for (int c = 0; c < 4; c++)
	begin
		case (col_sel)
			SHIFT_ROWS: col_next[c] = shifted[c];
			ADD_RK_OUT: col_next[c] = ark_col;
			default:    col_next[c] = block_in[(3-c)*32 +: 32];
		endcase
	end
end

// ==========================================================================
// Column registers
// ==========================================================================
// A shift commits the enabled column and rotates every column
assign col_we = (key_init || (col_sel == SHIFT_ROWS && |col_en)) ? 4'b1111 : col_en;

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		first_round <= 1'b0;
		for (int c = 0; c < 4; c++)
			col[c] <= 32'h0;
	end
	else
	begin
		if (key_init)
			first_round <= 1'b1;
		else if (col_sel == SHIFT_ROWS && |col_en)
			first_round <= 1'b0;
		for (int c = 0; c < 4; c++)
			if (col_we[c])
				col[c] <= col_next[c];
	end
end

assign state_out = {col[0], col[1], col[2], col[3]};

endmodule

// ==== verilog/aes_ctr_block.sv ====
// ==========================================================================
// Counter and output stage
// CTR counter, captured input block and ECB or CTR output selection
// ==========================================================================
`timescale 1ns/1ps

module aes_ctr_block
	import aes_pkg::*;
#(
	parameter int CTR_WIDTH = 32
)
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         key_init,
	input  logic         iv_load,
	input  logic [127:0] iv_in,
	input  logic [127:0] data_in,
	input  logic [1:0]   aes_mode,
	input  logic         end_comp,
	input  logic [127:0] state_out,
	output logic [127:0] block_in,
	output logic [127:0] data_out
);

// Increment field, carry stops at its top bit
localparam logic [127:0] CTR_MASK = {128{1'b1}} >> (128 - CTR_WIDTH);

logic [127:0] ctr;
logic [127:0] ctr_inc;
logic [127:0] data_q;
logic [127:0] out_q;
logic [127:0] result;

assign ctr_inc  = (ctr & ~CTR_MASK) | ((ctr + 128'd1) & CTR_MASK);
assign block_in = (aes_mode == CTR) ? ctr : data_in;

always_comb
begin
	case (aes_mode)
		ECB:     result = state_out;
		CTR:     result = state_out ^ data_q;
		default: result = state_out;
	endcase
end

// iv_load is meant for idle periods
always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		ctr   <= 128'h0;
		out_q <= 128'h0;
	end
	else
	begin
		if (iv_load)
			ctr <= iv_in;
		else if (end_comp && aes_mode == CTR)
			ctr <= ctr_inc;
		if (end_comp)
			out_q <= result;
	end
end

// Plaintext kept for the CTR keystream XOR
always_ff @(posedge clk)
begin
	if (key_init)
		data_q <= data_in;
end

// Result visible in the end_comp cycle and held afterwards
assign data_out = end_comp ? result : out_q;

endmodule

// ==== verilog/aes_core.sv ====
// ==========================================================================
// AES-128 encryption core
// Sequencer, key schedule, state columns and counter stage
// ==========================================================================
`timescale 1ns/1ps

module aes_core
#(
	parameter int CTR_WIDTH = 32
)
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic         disable_core,
	input  logic [1:0]   aes_mode,
	input  logic [127:0] key_in,
	input  logic [127:0] data_in,
	input  logic [127:0] iv_in,
	input  logic         iv_load,
	output logic [127:0] data_out,
	output logic         end_comp
);

logic         key_init;
logic [2:0]   sbox_sel;
logic [1:0]   col_sel;
logic [3:0]   col_en;
logic [3:0]   key_en;
logic [3:0]   round;
logic         last_round;
logic [31:0]  sbox_out;
logic [127:0] rk;
logic [127:0] state_out;
logic [127:0] block_in;

aes_control_unit u_ctrl
(
	.clk          (clk),
	.rst_n        (rst_n),
	.start        (start),
	.disable_core (disable_core),
	.aes_mode     (aes_mode),
	.key_init     (key_init),
	.sbox_sel     (sbox_sel),
	.col_sel      (col_sel),
	.col_en       (col_en),
	.key_en       (key_en),
	.round        (round),
	.last_round   (last_round),
	.end_comp     (end_comp)
);

// Key words advance alongside the columns
aes_key_schedule u_key
(
	.clk      (clk),
	.rst_n    (rst_n),
	.key_init (key_init),
	.key_in   (key_in),
	.key_en   (key_en),
	.round    (round),
	.sbox_out (sbox_out),
	.rk       (rk)
);

aes_state_columns u_cols
(
	.clk        (clk),
	.rst_n      (rst_n),
	.key_init   (key_init),
	.block_in   (block_in),
	.sbox_sel   (sbox_sel),
	.col_sel    (col_sel),
	.col_en     (col_en),
	.last_round (last_round),
	.rk         (rk),
	.sbox_out   (sbox_out),
	.state_out  (state_out)
);

aes_ctr_block #(
	.CTR_WIDTH (CTR_WIDTH)
) u_ctr
(
	.clk       (clk),
	.rst_n     (rst_n),
	.key_init  (key_init),
	.iv_load   (iv_load),
	.iv_in     (iv_in),
	.data_in   (data_in),
	.aes_mode  (aes_mode),
	.end_comp  (end_comp),
	.state_out (state_out),
	.block_in  (block_in),
	.data_out  (data_out)
);

endmodule

// ==== tests/aes_core_asserts.sv ====
// ==========================================================================
// AES sequencer assertions
// Pulse widths, one-hot enables and block latency
// ==========================================================================
`timescale 1ns/1ps

module aes_core_asserts
(
	input logic       clk,
	input logic       rst_n,
	input logic       key_init,
	input logic       disable_core,
	input logic [3:0] col_en,
	input logic [3:0] key_en,
	input logic       end_comp
);

// Done is a single-cycle pulse
a_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
	end_comp |=> !end_comp)
	else $error("end_comp high for more than one cycle");

// At most one column or key word written per cycle
a_col_onehot: assert property (@(posedge clk) disable iff (!rst_n)
	$onehot0(col_en))
	else $error("col_en not one-hot");

a_key_onehot: assert property (@(posedge clk) disable iff (!rst_n)
	$onehot0(key_en))
	else $error("key_en not one-hot");

// 4 round-0 columns plus 10 rounds of 5 cycles, aborts excluded
a_latency: assert property (@(posedge clk) disable iff (!rst_n || disable_core)
	key_init |-> ##55 end_comp)
	else $error("end_comp not 55 cycles after accepted start");

endmodule

bind aes_control_unit aes_core_asserts u_asserts
(
	.clk          (clk),
	.rst_n        (rst_n),
	.key_init     (key_init),
	.disable_core (disable_core),
	.col_en       (col_en),
	.key_en       (key_en),
	.end_comp     (end_comp)
);

// ==== tests/aes_core_tb.sv ====
// ==========================================================================
// AES-128 core testbench
// Known vectors, random ECB, CTR chaining, abort and busy-start behavior
// ==========================================================================
`timescale 1ns/1ps

module aes_core_tb
	import aes_pkg::*;
();

logic         clk = 1'b0;
logic         rst_n;
logic         start;
logic         disable_core;
logic [1:0]   aes_mode;
logic [127:0] key_in;
logic [127:0] data_in;
logic [127:0] iv_in;
logic         iv_load;
logic [127:0] data_out;
logic         end_comp;

// Reference S-box, built from the GF(2^8) inverse and affine map
logic [7:0]   sbox_ref [256];
// Results still owed by the DUT, oldest first
logic [127:0] expected_q [$];

always #5 clk = ~clk;

aes_core #(
	.CTR_WIDTH (32)
) u_dut
(
	.clk          (clk),
	.rst_n        (rst_n),
	.start        (start),
	.disable_core (disable_core),
	.aes_mode     (aes_mode),
	.key_in       (key_in),
	.data_in      (data_in),
	.iv_in        (iv_in),
	.iv_load      (iv_load),
	.data_out     (data_out),
	.end_comp     (end_comp)
);

// ==========================================================================
// Reporting
// ==========================================================================
task automatic stop_with_failure(input string why);
	$display("Error at %0t ns: %s", $time, why);
	$display("SIMULATION FAILED");
	$fatal(1, "run aborted");
endtask

task automatic check_value(input string what, input logic [127:0] actual,
	input logic [127:0] expected);
	if (actual !== expected)
	begin
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "value check failed");
	end
endtask

// ==========================================================================
// Reference model
// ==========================================================================
function automatic logic [7:0] gf_double(input logic [7:0] b);
	return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// Shift-and-add product in GF(2^8)
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	p = 8'h00;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			p = p ^ a;
		a = gf_double(a);
	end
	return p;
endfunction

function automatic void build_sbox();
	logic [7:0] b;
	for (int x = 0; x < 256; x++)
	begin
		// Inverse by search, zero maps to zero
		b = 8'h00;
		for (int y = 1; y < 256; y++)
			if (gf_mult(8'(x), 8'(y)) == 8'h01)
				b = 8'(y);
		sbox_ref[x] = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]}
			^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
	end
endfunction

// Full key expansion up front, byte i of the block at row i%4, column i/4
function automatic logic [127:0] aes128_encrypt(input logic [127:0] key,
	input logic [127:0] pt);
	logic [31:0]  w [44];
	logic [31:0]  t;
	logic [7:0]   rc;
	logic [7:0]   s [16];
	logic [7:0]   n [16];
	logic [127:0] ct;
	rc = 8'h01;
	for (int i = 0; i < 4; i++)
		w[i] = key[127 - 32*i -: 32];
	for (int i = 4; i < 44; i++)
	begin
		t = w[i-1];
		if (i % 4 == 0)
		begin
			t = {t[23:0], t[31:24]};
			t = {sbox_ref[t[31:24]], sbox_ref[t[23:16]], sbox_ref[t[15:8]], sbox_ref[t[7:0]]};
			t = t ^ {rc, 24'h000000};
			rc = gf_double(rc);
		end
		w[i] = w[i-4] ^ t;
	end
	for (int i = 0; i < 16; i++)
		s[i] = pt[127 - 8*i -: 8] ^ w[i/4][31 - 8*(i%4) -: 8];
	for (int r = 1; r <= 10; r++)
	begin
		// SubBytes with ShiftRows, row r moves left by r
		for (int i = 0; i < 16; i++)
			n[i] = sbox_ref[s[(i%4) + 4*(((i/4) + (i%4)) % 4)]];
		for (int c = 0; c < 4; c++)
		begin
			if (r < 10)
			begin
				s[4*c]   = gf_mult(8'h02, n[4*c]) ^ gf_mult(8'h03, n[4*c+1]) ^ n[4*c+2] ^ n[4*c+3];
				s[4*c+1] = n[4*c] ^ gf_mult(8'h02, n[4*c+1]) ^ gf_mult(8'h03, n[4*c+2]) ^ n[4*c+3];
				s[4*c+2] = n[4*c] ^ n[4*c+1] ^ gf_mult(8'h02, n[4*c+2]) ^ gf_mult(8'h03, n[4*c+3]);
				s[4*c+3] = gf_mult(8'h03, n[4*c]) ^ n[4*c+1] ^ n[4*c+2] ^ gf_mult(8'h02, n[4*c+3]);
			end
			else
			begin
				for (int k = 0; k < 4; k++)
					s[4*c+k] = n[4*c+k];
			end
		end
		for (int i = 0; i < 16; i++)
			s[i] = s[i] ^ w[4*r + i/4][31 - 8*(i%4) -: 8];
	end
	for (int i = 0; i < 16; i++)
		ct[127 - 8*i -: 8] = s[i];
	return ct;
endfunction

// Low 32 bits count, no carry into the upper bits
function automatic logic [127:0] increment_counter(input logic [127:0] ctr);
	return {ctr[127:32], ctr[31:0] + 32'd1};
endfunction

function automatic logic [127:0] rand128();
	return {$urandom(), $urandom(), $urandom(), $urandom()};
endfunction

// ==========================================================================
// Stimulus helpers
// ==========================================================================
task automatic pulse_start(input logic [1:0] mode, input logic [127:0] key,
	input logic [127:0] data);
	@(negedge clk);
	aes_mode = mode;
	key_in   = key;
	data_in  = data;
	start    = 1'b1;
	@(negedge clk);
	start = 1'b0;
endtask

task automatic launch_block(input logic [1:0] mode, input logic [127:0] key,
	input logic [127:0] data, input logic [127:0] expected);
	expected_q.push_back(expected);
	pulse_start(mode, key, data);
endtask

task automatic wait_results_drained(input int limit);
	int cycles;
	cycles = 0;
	while (expected_q.size() != 0)
	begin
		@(negedge clk);
		cycles++;
		if (cycles > limit)
			stop_with_failure("timeout waiting for end_comp");
	end
endtask

task automatic encrypt_and_check(input logic [1:0] mode, input logic [127:0] key,
	input logic [127:0] data, input logic [127:0] expected);
	launch_block(mode, key, data, expected);
	wait_results_drained(80);
endtask

task automatic load_counter(input logic [127:0] value);
	@(negedge clk);
	iv_in   = value;
	iv_load = 1'b1;
	@(negedge clk);
	iv_load = 1'b0;
endtask

// ==========================================================================
// Compare process
// ==========================================================================
// Outputs settle well before the falling edge
initial
begin : compare
	forever
	begin
		@(negedge clk);
		if (rst_n === 1'b1 && end_comp === 1'b1)
		begin
			if (expected_q.size() == 0)
				stop_with_failure("end_comp with no block outstanding");
			else
				check_value("data_out", data_out, expected_q.pop_front());
		end
	end
end

initial
begin : watchdog
	#200000;
	stop_with_failure("simulation watchdog expired");
end

// ==========================================================================
// Test sequence
// ==========================================================================
initial
begin : stimulus
	logic [127:0] key;
	logic [127:0] data;
	logic [127:0] ctr_model;
	logic [127:0] held;
	logic [1:0]   mode;
	void'($urandom(32'h8811));
	rst_n        = 1'b0;
	start        = 1'b0;
	disable_core = 1'b0;
	aes_mode     = ECB;
	key_in       = 128'h0;
	data_in      = 128'h0;
	iv_in        = 128'h0;
	iv_load      = 1'b0;
	build_sbox();
	repeat (4) @(negedge clk);
	rst_n = 1'b1;

	// FIPS-197 appendix vectors, model first
	check_value("reference C.1", aes128_encrypt(128'h000102030405060708090a0b0c0d0e0f,
		128'h00112233445566778899aabbccddeeff), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
	encrypt_and_check(ECB, 128'h000102030405060708090a0b0c0d0e0f,
		128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
	encrypt_and_check(ECB, 128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h3243f6a8885a308d313198a2e0370734, 128'h3925841d02dc09fbdc118597196a0b32);

	// Random ECB, codes 01 and 11 behave as ECB
	for (int i = 0; i < 20; i++)
	begin
		key  = rand128();
		data = rand128();
		mode = (i % 3 == 0) ? ECB : ((i % 3 == 1) ? 2'b01 : 2'b11);
		encrypt_and_check(mode, key, data, aes128_encrypt(key, data));
	end

	// CTR across the 32-bit wrap
	key       = rand128();
	held      = rand128();
	ctr_model = {held[127:32], 32'hffff_fffe};
	load_counter(ctr_model);
	for (int i = 0; i < 4; i++)
	begin
		data = rand128();
		encrypt_and_check(CTR, key, data, data ^ aes128_encrypt(key, ctr_model));
		ctr_model = increment_counter(ctr_model);
	end

	// Abort mid-block, counter and output must hold
	held = data_out;
	pulse_start(CTR, key, rand128());
	repeat (20) @(negedge clk);
	disable_core = 1'b1;
	@(negedge clk);
	disable_core = 1'b0;
	for (int i = 0; i < 100; i++)
	begin
		@(negedge clk);
		if (end_comp)
			stop_with_failure("end_comp after disable_core");
	end
	check_value("data_out after abort", data_out, held);
	data = rand128();
	encrypt_and_check(CTR, key, data, data ^ aes128_encrypt(key, ctr_model));

	// Second start while busy is dropped
	// A stray end_comp in the quiet window has no block outstanding
	key  = rand128();
	data = rand128();
	launch_block(ECB, key, data, aes128_encrypt(key, data));
	repeat (10) @(negedge clk);
	pulse_start(ECB, rand128(), rand128());
	wait_results_drained(80);
	repeat (60) @(negedge clk);

	$display("SIMULATION PASSED");
	$finish;
end

endmodule

// ==== tb.f ====
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_control_unit.sv
verilog/aes_key_schedule.sv
verilog/aes_state_columns.sv
verilog/aes_ctr_block.sv
verilog/aes_core.sv
tests/aes_core_asserts.sv
tests/aes_core_tb.sv

// ==== Makefile ====
# Verilator simulation of the AES-128 core

VERILATOR ?= verilator
TOP       ?= aes_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
